//--- ex_pkg.sv
package ex_pkg;

    localparam int WORD_W = 32;

    typedef logic [WORD_W-1:0] word_t;       // Operands, pc, label and results
    typedef logic [6:0]        opcode_t;
    typedef logic [2:0]        func3_t;
    typedef logic [6:0]        ctrl_t;
    typedef logic [7:0]        phys_reg_t;   // Physical destination tag

    localparam opcode_t OPC_MUL = 7'b0110011;
    localparam opcode_t OPC_DIV = 7'b1001111;

    localparam int CTRL_BRANCH = 0;          // Conditional branch flag in ctrl

    // Add unit; for branches F_ADD is beq and F_SUB is bne
    localparam func3_t F_ADD   = 3'b000;
    localparam func3_t F_SUB   = 3'b001;
    localparam func3_t F_AND   = 3'b010;
    localparam func3_t F_OR    = 3'b011;
    localparam func3_t F_XOR   = 3'b100;
    localparam func3_t F_SLTU  = 3'b101;

    localparam func3_t F_MUL   = 3'b000;     // Low word of product
    localparam func3_t F_MULHU = 3'b011;     // High word, unsigned
    localparam func3_t F_DIVU  = 3'b101;
    localparam func3_t F_REMU  = 3'b111;

    localparam int ISSUE_CREDITS = 2;        // Dispatcher queue depth
    localparam int ADD_CREDITS   = 1;
    localparam int MUL_CREDITS   = 2;
    localparam int DIV_CREDITS   = 1;
    localparam int NUM_UNITS     = 3;
    localparam int CREDIT_W      = 2;
    localparam int DIV_STEPS     = 32;       // One quotient bit per step

    typedef logic [CREDIT_W-1:0] credit_t;

    typedef enum logic [1:0] {
        UNIT_ADD,
        UNIT_MUL,
        UNIT_DIV
    } unit_sel_e;

    // Reset value of each unit's credit counter, indexed by unit_sel_e
    localparam credit_t UNIT_CREDITS [NUM_UNITS] = '{
        credit_t'(ADD_CREDITS),
        credit_t'(MUL_CREDITS),
        credit_t'(DIV_CREDITS)
    };

    typedef enum logic [1:0] {
        IDLE,
        RUN,
        DONE
    } div_state_e;

    typedef struct packed {
        func3_t    func3;
        word_t     operand1;
        word_t     operand2;
        word_t     pc;
        word_t     label;      // Branch immediate
        ctrl_t     ctrl;
        phys_reg_t rd;
    } exe_op_t;

    typedef struct packed {
        opcode_t opcode;
        exe_op_t op;
    } issue_op_t;

    typedef struct packed {
        phys_reg_t rd;
        word_t     data;
    } unit_res_t;

endpackage

//--- ex_dispatch.sv
module ex_dispatch
    import ex_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  logic      issue_valid,
    input  issue_op_t issue_op,
    input  logic      add_credit,
    input  logic      mul_credit,
    input  logic      div_credit,
    output logic      issue_credit,
    output logic      add_valid,
    output logic      mul_valid,
    output logic      div_valid,
    output exe_op_t   exe_op
);

    issue_op_t                              q_mem [ISSUE_CREDITS];
    logic [$clog2(ISSUE_CREDITS)-1:0]       wr_ptr;
    logic [$clog2(ISSUE_CREDITS)-1:0]       rd_ptr;
    logic [$clog2(ISSUE_CREDITS+1)-1:0]     q_cnt;
    issue_op_t                              head;
    unit_sel_e                              head_sel;
    logic                                   pop;
    logic [NUM_UNITS-1:0]                   take;      // One-hot dispatch target
    logic [NUM_UNITS-1:0]                   disp_q;    // Registered unit valids
    logic [NUM_UNITS-1:0]                   cred_ret;
    credit_t                                cnt [NUM_UNITS];

    assign head     = q_mem[rd_ptr];
    assign cred_ret = {div_credit, mul_credit, add_credit};

    // Opcode router with the add unit as default target
    always_comb begin
        case (head.opcode)
            OPC_MUL: head_sel = UNIT_MUL;
            OPC_DIV: head_sel = UNIT_DIV;
            default: head_sel = UNIT_ADD;
        endcase
    end

    assign pop  = (q_cnt != '0) && (cnt[head_sel] != '0);
    assign take = pop ? (NUM_UNITS'(1) << head_sel) : '0;

    always_ff @(posedge clk) begin
        if (issue_valid) begin
            q_mem[wr_ptr] <= issue_op;
        end
        if (pop) begin
            exe_op <= head.op;    // Shared payload qualified by the unit valids
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr       <= '0;
            rd_ptr       <= '0;
            q_cnt        <= '0;
            issue_credit <= 1'b0;
            disp_q       <= '0;
            for (int i = 0; i < NUM_UNITS; i++) begin
                cnt[i] <= UNIT_CREDITS[i];
            end
        end else begin
            if (issue_valid) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            q_cnt        <= q_cnt + $bits(q_cnt)'(issue_valid) - $bits(q_cnt)'(pop);
            issue_credit <= pop;    // Freed slot goes back to the RS
            disp_q       <= take;
            for (int i = 0; i < NUM_UNITS; i++) begin
                cnt[i] <= cnt[i] - credit_t'(take[i]) + credit_t'(cred_ret[i]);
            end
        end
    end

    assign add_valid = disp_q[UNIT_ADD];
    assign mul_valid = disp_q[UNIT_MUL];
    assign div_valid = disp_q[UNIT_DIV];

    for (genvar u = 0; u < NUM_UNITS; u++) begin : g_credit_chk
        a_credit_max: assert property (@(posedge clk) disable iff (!rst_n)
            cnt[u] <= UNIT_CREDITS[u]);    // Catches spurious credit pulses
    end

    a_no_overflow: assert property (@(posedge clk) disable iff (!rst_n)
        issue_valid |-> q_cnt < ISSUE_CREDITS);

endmodule

//--- add_alu.sv
module add_alu
    import ex_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  logic      op_valid,
    input  exe_op_t   op,
    input  logic      grant,
    output logic      res_valid,
    output unit_res_t res,
    output logic      credit
);

    word_t result;
    logic  taken;

    always_comb begin
        taken = 1'b0;
        case (op.func3)
            F_ADD:   result = op.operand1 + op.operand2;
            F_SUB:   result = op.operand1 - op.operand2;
            F_AND:   result = op.operand1 & op.operand2;
            F_OR:    result = op.operand1 | op.operand2;
            F_XOR:   result = op.operand1 ^ op.operand2;
            F_SLTU:  result = word_t'(op.operand1 < op.operand2);
            default: result = op.operand1 + op.operand2;
        endcase
        if (op.ctrl[CTRL_BRANCH]) begin
            // bne on F_SUB, beq otherwise
            taken  = (op.func3 == F_SUB) ? (op.operand1 != op.operand2)
                                         : (op.operand1 == op.operand2);
            result = taken ? op.pc + op.label : op.pc + word_t'(4);    // Next pc
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            res_valid <= 1'b0;
        end else if (op_valid) begin
            res_valid <= 1'b1;
        end else if (grant) begin
            res_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (op_valid) begin
            res <= '{rd: op.rd, data: result};    // Held until granted
        end
    end

    assign credit = grant;    // Single slot frees on grant

endmodule

//--- mul_unit.sv
module mul_unit
    import ex_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  logic      op_valid,
    input  exe_op_t   op,
    input  logic      grant,
    output logic      res_valid,
    output unit_res_t res,
    output logic      credit
);

    logic [2*WORD_W-1:0] prod_q;
    func3_t              f3_q;
    phys_reg_t           rd_q;
    logic                s1_valid;
    logic                adv;

    // Stage 1 moves on when the output slot is empty or leaving this cycle
    assign adv = s1_valid && (!res_valid || grant);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            s1_valid  <= 1'b0;
            res_valid <= 1'b0;
        end else begin
            if (op_valid) begin
                s1_valid <= 1'b1;
            end else if (adv) begin
                s1_valid <= 1'b0;
            end
            if (adv) begin
                res_valid <= 1'b1;
            end else if (grant) begin
                res_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (op_valid) begin
            prod_q <= (2*WORD_W)'(op.operand1) * (2*WORD_W)'(op.operand2);    // Unsigned
            f3_q   <= op.func3;
            rd_q   <= op.rd;
        end
        if (adv) begin
            res.rd   <= rd_q;
            res.data <= (f3_q == F_MULHU) ? prod_q[2*WORD_W-1:WORD_W] : prod_q[WORD_W-1:0];
        end
    end

    assign credit = grant;

endmodule

//--- div_unit.sv
module div_unit
    import ex_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  logic      op_valid,
    input  exe_op_t   op,
    input  logic      grant,
    output logic      res_valid,
    output unit_res_t res,
    output logic      credit
);

    localparam int STEP_W = $clog2(DIV_STEPS);

    div_state_e        state;
    logic [STEP_W-1:0] step;
    word_t             quo;         // Dividend shifts out, quotient shifts in
    word_t             rem;
    word_t             divisor;
    func3_t            f3_q;
    phys_reg_t         rd_q;
    logic [WORD_W:0]   rem_sh;
    logic              fits;

    // Restoring step; a zero divisor always fits, which yields the
    // RISC-V result of all-ones quotient and remainder equal to dividend
    assign rem_sh = {rem, quo[WORD_W-1]};
    assign fits   = rem_sh >= {1'b0, divisor};

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= IDLE;
            step  <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (op_valid) begin
                        state <= RUN;
                        step  <= '0;
                    end
                end
                RUN: begin
                    step <= step + 1'b1;
                    if (step == STEP_W'(DIV_STEPS - 1)) begin
                        state <= DONE;
                    end
                end
                DONE: begin
                    if (grant) begin
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == IDLE && op_valid) begin
            quo     <= op.operand1;
            rem     <= '0;
            divisor <= op.operand2;
            f3_q    <= op.func3;
            rd_q    <= op.rd;
        end else if (state == RUN) begin
            quo <= {quo[WORD_W-2:0], fits};
            rem <= fits ? WORD_W'(rem_sh - {1'b0, divisor}) : rem_sh[WORD_W-1:0];
        end
    end

    assign res_valid = (state == DONE);
    assign res       = '{rd: rd_q, data: (f3_q == F_REMU) ? rem : quo};
    assign credit    = grant;    // Unit is free again once its result is taken

    a_busy_no_op: assert property (@(posedge clk) disable iff (!rst_n)
        op_valid |-> state == IDLE);

endmodule

//--- wb_arbiter.sv
module wb_arbiter
    import ex_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  logic      add_res_valid,
    input  logic      mul_res_valid,
    input  logic      div_res_valid,
    input  unit_res_t add_res,
    input  unit_res_t mul_res,
    input  unit_res_t div_res,
    output logic      add_grant,
    output logic      mul_grant,
    output logic      div_grant,
    output logic      wb_valid,
    output phys_reg_t wb_rd,
    output word_t     wb_data
);

    unit_sel_e sel;
    logic      any_req;
    unit_res_t win;

    // Divider first since it holds the longest and the multiplier next
    always_comb begin
        any_req = 1'b1;
        if (div_res_valid) begin
            sel = UNIT_DIV;
        end else if (mul_res_valid) begin
            sel = UNIT_MUL;
        end else if (add_res_valid) begin
            sel = UNIT_ADD;
        end else begin
            sel     = UNIT_ADD;
            any_req = 1'b0;
        end
    end

    always_comb begin
        case (sel)
            UNIT_DIV: win = div_res;
            UNIT_MUL: win = mul_res;
            default:  win = add_res;
        endcase
    end

    assign div_grant = any_req && (sel == UNIT_DIV);
    assign mul_grant = any_req && (sel == UNIT_MUL);
    assign add_grant = any_req && (sel == UNIT_ADD);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wb_valid <= 1'b0;
        end else begin
            wb_valid <= any_req;
        end
    end

    always_ff @(posedge clk) begin
        if (any_req) begin
            wb_rd   <= win.rd;
            wb_data <= win.data;
        end
    end

    // A unit that loses arbitration keeps its result for the next round
    a_div_hold: assert property (@(posedge clk) disable iff (!rst_n)
        div_res_valid && !div_grant |=> div_res_valid && $stable(div_res));
    a_mul_hold: assert property (@(posedge clk) disable iff (!rst_n)
        mul_res_valid && !mul_grant |=> mul_res_valid && $stable(mul_res));
    a_add_hold: assert property (@(posedge clk) disable iff (!rst_n)
        add_res_valid && !add_grant |=> add_res_valid && $stable(add_res));

endmodule

//--- ex_cluster.sv
module ex_cluster
    import ex_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  logic      issue_valid,
    input  issue_op_t issue_op,
    output logic      issue_credit,
    output logic      wb_valid,
    output phys_reg_t wb_rd,
    output word_t     wb_data
);

    exe_op_t   exe_op;
    logic      add_valid,  mul_valid,  div_valid;
    logic      add_credit, mul_credit, div_credit;
    logic      add_grant,  mul_grant,  div_grant;
    logic      add_res_valid, mul_res_valid, div_res_valid;
    unit_res_t add_res, mul_res, div_res;

    ex_dispatch i_dispatch (
        .clk          (clk),
        .rst_n        (rst_n),
        .issue_valid  (issue_valid),
        .issue_op     (issue_op),
        .add_credit   (add_credit),
        .mul_credit   (mul_credit),
        .div_credit   (div_credit),
        .issue_credit (issue_credit),
        .add_valid    (add_valid),
        .mul_valid    (mul_valid),
        .div_valid    (div_valid),
        .exe_op       (exe_op)
    );

    add_alu i_add (
        .clk       (clk),
        .rst_n     (rst_n),
        .op_valid  (add_valid),
        .op        (exe_op),
        .grant     (add_grant),
        .res_valid (add_res_valid),
        .res       (add_res),
        .credit    (add_credit)
    );

    mul_unit i_mul (
        .clk       (clk),
        .rst_n     (rst_n),
        .op_valid  (mul_valid),
        .op        (exe_op),
        .grant     (mul_grant),
        .res_valid (mul_res_valid),
        .res       (mul_res),
        .credit    (mul_credit)
    );

    div_unit i_div (
        .clk       (clk),
        .rst_n     (rst_n),
        .op_valid  (div_valid),
        .op        (exe_op),
        .grant     (div_grant),
        .res_valid (div_res_valid),
        .res       (div_res),
        .credit    (div_credit)
    );

    wb_arbiter i_arb (
        .clk           (clk),
        .rst_n         (rst_n),
        .add_res_valid (add_res_valid),
        .mul_res_valid (mul_res_valid),
        .div_res_valid (div_res_valid),
        .add_res       (add_res),
        .mul_res       (mul_res),
        .div_res       (div_res),
        .add_grant     (add_grant),
        .mul_grant     (mul_grant),
        .div_grant     (div_grant),
        .wb_valid      (wb_valid),
        .wb_rd         (wb_rd),
        .wb_data       (wb_data)
    );

endmodule

//--- tb_ex_cluster.sv
module tb_ex_cluster
    import ex_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int      CLK_PERIOD      = 40;
    localparam opcode_t OPC_ALU         = 7'b0010011;
    localparam opcode_t OPC_BR          = 7'b1100011;
    localparam int      N_ADD           = 36;
    localparam int      N_BR            = 8;
    localparam int      N_MUL           = 16;
    localparam int      N_DIV           = 16;
    localparam int      N_BURST         = 200;
    localparam int      TOTAL_ISSUES    = N_ADD + N_BR + N_MUL + N_DIV + N_BURST;
    localparam int      WATCHDOG_CYCLES = TOTAL_ISSUES * 60 + 400;

    localparam func3_t ADD_FUNCS [6] = '{F_ADD, F_SUB, F_AND, F_OR, F_XOR, F_SLTU};
    localparam word_t  EDGE_A [4] = '{32'h0000_0000, 32'hffff_ffff, 32'h8000_0000, 32'hffff_ffff};
    localparam word_t  EDGE_B [4] = '{32'h0000_0000, 32'h0000_0001, 32'h7fff_ffff, 32'hffff_ffff};
    localparam word_t  DIV_A [6] = '{32'd100, 32'd5, 32'd1234, 32'hffff_ffff, 32'hffff_ffff,
                                     32'h8000_0000};
    localparam word_t  DIV_B [6] = '{32'd7, 32'd9, 32'd0, 32'd1, 32'hffff_ffff, 32'd3};

    logic      clk;
    logic      rst_n;
    logic      issue_valid;
    issue_op_t issue_op;
    logic      issue_credit;
    logic      wb_valid;
    phys_reg_t wb_rd;
    word_t     wb_data;

    word_t     exp_data [256];    // Expected result per tag
    logic      pending  [256];
    phys_reg_t next_tag;
    int        credits;
    int        outstanding;
    int        issued_total;
    int        retired_total;
    int        credit_pulses;
    int        errors;
    int        tests_run;
    int        tests_failed;
    int        err_start;
    int        issue_start;
    int        retire_start;
    int        pulse_start;

    ex_cluster i_dut (
        .clk          (clk),
        .rst_n        (rst_n),
        .issue_valid  (issue_valid),
        .issue_op     (issue_op),
        .issue_credit (issue_credit),
        .wb_valid     (wb_valid),
        .wb_rd        (wb_rd),
        .wb_data      (wb_data)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic word_t rand_edge();
        case ($urandom_range(0, 5))
            0:       return 32'h0000_0000;
            1:       return 32'hffff_ffff;
            2:       return 32'h8000_0000;
            3:       return 32'h7fff_ffff;
            4:       return $urandom_range(0, 15);
            default: return $urandom;
        endcase
    endfunction

    function automatic issue_op_t make_op(input opcode_t opc, input func3_t f3, input word_t a,
                                          input word_t b, input word_t pc, input word_t label,
                                          input logic br);
        issue_op_t ins;
        ins                     = '0;
        ins.opcode              = opc;
        ins.op.func3            = f3;
        ins.op.operand1         = a;
        ins.op.operand2         = b;
        ins.op.pc               = pc;
        ins.op.label            = label;
        ins.op.ctrl[CTRL_BRANCH] = br;
        return ins;
    endfunction

    // Expected writeback value from the opcode routing and unit rules
    function automatic word_t ref_result(input issue_op_t ins);
        logic [63:0] prod;
        word_t       a;
        word_t       b;
        logic        taken;
        a    = ins.op.operand1;
        b    = ins.op.operand2;
        prod = {32'b0, a} * {32'b0, b};
        if (ins.opcode == OPC_MUL) begin
            return (ins.op.func3 == F_MULHU) ? prod[63:32] : prod[31:0];
        end
        if (ins.opcode == OPC_DIV) begin
            if (b == '0) begin
                return (ins.op.func3 == F_REMU) ? a : 32'hffff_ffff;    // Divide by zero
            end
            return (ins.op.func3 == F_REMU) ? a % b : a / b;
        end
        if (ins.op.ctrl[CTRL_BRANCH]) begin
            taken = (ins.op.func3 == F_SUB) ? (a != b) : (a == b);
            return taken ? ins.op.pc + ins.op.label : ins.op.pc + 32'd4;
        end
        case (ins.op.func3)
            F_SUB:   return a - b;
            F_AND:   return a & b;
            F_OR:    return a | b;
            F_XOR:   return a ^ b;
            F_SLTU:  return {31'b0, a < b};
            default: return a + b;
        endcase
    endfunction

    task automatic issue_one(input issue_op_t ins_in);
        issue_op_t ins;
        ins = ins_in;
        @(posedge clk);
        #2;
        issue_valid = 1'b0;
        while (credits == 0) begin    // Hold off until the RS has a credit
            @(posedge clk);
            #2;
        end
        ins.op.rd          = next_tag;
        exp_data[next_tag] = ref_result(ins);
        pending[next_tag]  = 1'b1;
        next_tag           = next_tag + 1'b1;
        issue_op           = ins;
        issue_valid        = 1'b1;
        credits--;
        outstanding++;
        issued_total++;
    endtask

    task automatic drain(input int limit);
        int waited;
        waited = 0;
        @(posedge clk);
        #2;
        issue_valid = 1'b0;
        while (outstanding != 0 && waited < limit) begin
            @(posedge clk);
            waited++;
        end
        assert (outstanding == 0) else begin
            $display("Results missing at %0t: %0d issued tags never came back", $time,
                     outstanding);
            errors++;
        end
    endtask

    task automatic start_test();
        err_start    = errors;
        issue_start  = issued_total;
        retire_start = retired_total;
        pulse_start  = credit_pulses;
    endtask

    task automatic report_test(input string name);
        tests_run++;
        if (errors != err_start) begin
            tests_failed++;
        end
        $display("Test %-7s %s  issued %0d  retired %0d  errors %0d", name,
                 (errors == err_start) ? "PASS" : "FAIL", issued_total - issue_start,
                 retired_total - retire_start, errors - err_start);
    endtask

    task automatic test_idle();
        start_test();
        repeat (6) begin
            @(negedge clk);
            assert (!wb_valid) else begin
                $display("Mismatch at %0t: wb_valid got %b expected 0", $time, wb_valid);
                errors++;
            end
            assert (!issue_credit) else begin
                $display("Mismatch at %0t: issue_credit got %b expected 0", $time,
                         issue_credit);
                errors++;
            end
        end
        report_test("idle");
    endtask

    task automatic test_add();
        word_t a;
        word_t b;
        start_test();
        for (int f = 0; f < 6; f++) begin
            for (int i = 0; i < 6; i++) begin
                a = (i < 4) ? EDGE_A[i] : rand_edge();
                b = (i < 4) ? EDGE_B[i] : rand_edge();
                issue_one(make_op(OPC_ALU, ADD_FUNCS[f], a, b, $urandom, $urandom, 1'b0));
            end
        end
        drain(N_ADD * 60 + 100);
        report_test("add");
    endtask

    task automatic test_branch();
        word_t  a;
        word_t  b;
        func3_t f3;
        start_test();
        for (int rep = 0; rep < 2; rep++) begin
            for (int kind = 0; kind < 4; kind++) begin
                f3 = (kind >= 2) ? F_SUB : F_ADD;    // beq first, then bne
                a  = rand_edge();
                b  = (kind % 2 == 0) ? a : ~a;
                issue_one(make_op(OPC_BR, f3, a, b, $urandom & 32'hffff_fffc,
                                  $urandom & 32'hffff_fffe, 1'b1));
            end
        end
        drain(N_BR * 60 + 100);
        report_test("branch");
    endtask

    task automatic test_mul();
        word_t  a;
        word_t  b;
        func3_t f3;
        start_test();
        for (int f = 0; f < 2; f++) begin
            f3 = (f == 0) ? F_MUL : F_MULHU;
            for (int i = 0; i < 8; i++) begin
                a = (i < 4) ? EDGE_A[i] : $urandom;
                b = (i < 4) ? EDGE_B[i] : $urandom;
                issue_one(make_op(OPC_MUL, f3, a, b, $urandom, $urandom, 1'b0));
            end
        end
        drain(N_MUL * 60 + 100);
        report_test("mul");
    endtask

    task automatic test_div();
        word_t  a;
        word_t  b;
        func3_t f3;
        start_test();
        for (int f = 0; f < 2; f++) begin
            f3 = (f == 0) ? F_DIVU : F_REMU;
            for (int i = 0; i < 8; i++) begin
                a = (i < 6) ? DIV_A[i] : $urandom;
                b = (i < 6) ? DIV_B[i] : $urandom_range(1, 65535);
                issue_one(make_op(OPC_DIV, f3, a, b, $urandom, $urandom, 1'b0));
            end
        end
        drain(N_DIV * 60 + 100);
        report_test("div");
    endtask

    task automatic test_burst();
        int    pick;
        word_t a;
        word_t b;
        start_test();
        for (int n = 0; n < N_BURST; n++) begin
            pick = $urandom_range(0, 15);
            a    = rand_edge();
            b    = rand_edge();
            if (pick < 8) begin
                issue_one(make_op(OPC_ALU, ADD_FUNCS[$urandom_range(0, 5)], a, b, $urandom,
                                  $urandom, 1'b0));
            end else if (pick < 10) begin
                b = (pick == 8) ? a : b;
                issue_one(make_op(OPC_BR, ($urandom_range(0, 1) == 1) ? F_SUB : F_ADD, a, b,
                                  $urandom & 32'hffff_fffc, $urandom & 32'hffff_fffe, 1'b1));
            end else if (pick < 14) begin
                issue_one(make_op(OPC_MUL, ($urandom_range(0, 1) == 1) ? F_MULHU : F_MUL, a, b,
                                  $urandom, $urandom, 1'b0));
            end else begin
                if ($urandom_range(0, 3) == 0) begin
                    b = '0;
                end
                issue_one(make_op(OPC_DIV, ($urandom_range(0, 1) == 1) ? F_REMU : F_DIVU, a, b,
                                  $urandom, $urandom, 1'b0));
            end
        end
        drain(N_BURST * 60 + 100);
        assert (retired_total - retire_start == issued_total - issue_start) else begin
            $display("Mismatch at %0t: retired count got %0d expected %0d", $time,
                     retired_total - retire_start, issued_total - issue_start);
            errors++;
        end
        assert (credit_pulses - pulse_start == issued_total - issue_start) else begin
            $display("Mismatch at %0t: issue_credit pulses got %0d expected %0d", $time,
                     credit_pulses - pulse_start, issued_total - issue_start);
            errors++;
        end
        report_test("burst");
    endtask

    // Returned issue credits
    always @(posedge clk) begin
        if (rst_n && issue_credit) begin
            credits++;
            credit_pulses++;
            assert (credits <= ISSUE_CREDITS) else begin
                $display("Extra issue_credit pulse at %0t: credit count exceeds queue depth",
                         $time);
                errors++;
            end
        end
    end

    // Scoreboard keyed by the result tag
    always @(posedge clk) begin
        if (rst_n && wb_valid) begin
            assert (pending[wb_rd]) else begin
                $display("Unexpected result at %0t: tag %0d not issued or already retired",
                         $time, wb_rd);
                errors++;
            end
            if (pending[wb_rd]) begin
                assert (wb_data == exp_data[wb_rd]) else begin
                    $display("Mismatch at %0t: wb_data for tag %0d got %h expected %h", $time,
                             wb_rd, wb_data, exp_data[wb_rd]);
                    errors++;
                end
                pending[wb_rd] = 1'b0;
                outstanding--;
                retired_total++;
            end
        end
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Watchdog expired at %0t: the run did not finish in time", $time);
        $display("Simulation failed");
        $finish;
    end

    initial begin
        clk           = 1'b0;
        rst_n         = 1'b0;
        issue_valid   = 1'b0;
        issue_op      = '0;
        next_tag      = '0;
        credits       = ISSUE_CREDITS;
        outstanding   = 0;
        issued_total  = 0;
        retired_total = 0;
        credit_pulses = 0;
        errors        = 0;
        tests_run     = 0;
        tests_failed  = 0;
        for (int t = 0; t < 256; t++) begin
            pending[t] = 1'b0;
        end
        void'($urandom(93359));
        repeat (2) @(posedge clk);
        #2;
        rst_n = 1'b1;

        test_idle();
        test_add();
        test_branch();
        test_mul();
        test_div();
        test_burst();

        $display("Summary: %0d tests, %0d failed, %0d issued, %0d retired, %0d errors",
                 tests_run, tests_failed, issued_total, retired_total, errors);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

//--- ex_cluster.f
ex_pkg.sv
ex_dispatch.sv
add_alu.sv
mul_unit.sv
div_unit.sv
wb_arbiter.sv
ex_cluster.sv
tb_ex_cluster.sv

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_ex_cluster -f ex_cluster.f

./obj_dir/Vtb_ex_cluster > sim.log 2>&1
cat sim.log

if grep -q "Simulation failed" sim.log; then
    exit 1
fi
grep -q "Simulation completed successfully" sim.log
